/* hw/video_pkg.sv */
// ======================================================================
// Shared definitions for the character-layer video pipeline
// Raster constants, RAM sizes, the host write bus and one struct per
// pipeline stage. Modules import it inside their body and use scoped
// names on their ports.
// ======================================================================
package video_pkg;

    // Horizontal raster, counted in pixel clocks
    localparam logic [8:0] H_TOTAL  = 9'd384;
    localparam logic [8:0] H_ACTIVE = 9'd256;  // hbl from here to line end
    localparam logic [8:0] HS_START = 9'd309;
    localparam logic [8:0] HS_END   = 9'd329;  // first count with hs low

    // Vertical raster, line numbers as the counter sees them
    localparam logic [7:0] V_FIRST   = 8'h08;  // main pass starts here
    localparam logic [7:0] V_REPEAT  = 8'hE8;  // blanked second pass
    localparam logic [7:0] VBL_START = 8'hF8;
    localparam logic [7:0] VS_START  = 8'hE9;  // second pass only
    localparam logic [7:0] VS_END    = 8'hED;

    // RAM depths
    localparam int TILEMAP_DEPTH = 1024;  // 32x32 cells
    localparam int PATTERN_DEPTH = 128;   // 16 patterns x 8 rows
    localparam int PALETTE_DEPTH = 32;    // 16 groups x 2 colours

    // Target of a host write
    typedef enum logic [1:0] {
        SEL_TILEMAP = 2'd0,
        SEL_PATTERN = 2'd1,
        SEL_PALETTE = 2'd2
    } ram_sel_e;

    typedef struct packed {
        logic        we;
        ram_sel_e    sel;
        logic [9:0]  addr;
        logic [10:0] data;   // Low bits used per RAM
    } host_wr_t;

    // Raster state that travels with every pixel
    typedef struct packed {
        logic [7:0] hpos;    // Flip applied
        logic [7:0] vpos;    // Flip applied
        logic       hbl;
        logic       vbl;
        logic       hs;
        logic       vs;
    } vid_timing_t;

    typedef struct packed {
        vid_timing_t timing;
        logic [7:0]  code;   // Hi nibble palette group, lo nibble pattern
        logic [2:0]  row;
        logic [2:0]  col;
    } tile_stage_t;

    typedef struct packed {
        vid_timing_t timing;
        logic [4:0]  colour; // Palette group then pixel bit
    } pat_stage_t;

    typedef struct packed {
        vid_timing_t timing;
        logic [11:0] rgb;
    } video_out_t;

endpackage

/* hw/video_timing.sv */
// ======================================================================
// Raster timing generator
// Runs the horizontal and vertical counters on pxl_cen, derives the
// blanking and sync levels and the flip-aware pixel position, and
// registers them as one struct for the pixel pipeline.
// ======================================================================
`timescale 1ns/1ps

module video_timing (
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   pxl_cen,
    input  logic                   flip,
    output video_pkg::vid_timing_t timing
);
    import video_pkg::*;

    logic [8:0]  hcnt;         // 0..383
    logic [7:0]  vcnt;         // Line number
    logic        second_pass;  // Repeat of lines E8..FF, always blanked
    logic        line_end;
    vid_timing_t nxt;

    assign line_end = (hcnt == H_TOTAL - 9'd1);

    // Counters
    // Line sequence is 08..FF then E8..FF, 272 lines per frame
    always_ff @(posedge clk) begin
        if (reset) begin
            hcnt        <= '0;
            vcnt        <= V_REPEAT;
            second_pass <= 1'b1;   // Start blanked, first frame is whole
        end else if (pxl_cen) begin
            if (line_end) begin
                hcnt <= '0;
                if (&vcnt) begin
                    // Alternate between main and repeat pass
                    vcnt        <= second_pass ? V_FIRST : V_REPEAT;
                    second_pass <= ~second_pass;
                end else begin
                    vcnt <= vcnt + 8'd1;
                end
            end else begin
                hcnt <= hcnt + 9'd1;
            end
        end
    end

    // Raster levels for the current count
    always_comb begin
        nxt.hpos = hcnt[7:0] ^ {8{flip}};
        nxt.vpos = vcnt ^ {8{flip}};
        nxt.hbl  = (hcnt >= H_ACTIVE);
        nxt.hs   = (hcnt >= HS_START) && (hcnt < HS_END);   // 20 clocks

        // Blanked through the repeat pass and the first main line
        nxt.vbl = second_pass || (vcnt >= VBL_START) || (vcnt == V_FIRST);

        // vs edges line up with the hs rise
        nxt.vs = 1'b0;
        if (second_pass) begin
            if (vcnt == VS_START) begin
                nxt.vs = (hcnt >= HS_START);
            end else if ((vcnt > VS_START) && (vcnt < VS_END)) begin
                nxt.vs = 1'b1;
            end else if (vcnt == VS_END) begin
                nxt.vs = (hcnt < HS_START);   // Falls at hs rise
            end
        end
    end

    // One enabled cycle after the counters
    always_ff @(posedge clk) begin
        if (reset) begin
            timing <= '0;
        end else if (pxl_cen) begin
            timing <= nxt;
        end
    end

endmodule

/* hw/tile_fetch.sv */
// ======================================================================
// Tile-map stage
// Holds the 32x32 tile map written by the host. Each pixel enable
// looks up the code of the 8x8 cell under the pixel and passes it on
// with the in-tile row and column and the timing.
// ======================================================================
`timescale 1ns/1ps

module tile_fetch (
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   pxl_cen,
    input  video_pkg::host_wr_t    host,
    input  video_pkg::vid_timing_t timing,
    output video_pkg::tile_stage_t tile
);
    import video_pkg::*;

    logic [7:0] tile_ram [TILEMAP_DEPTH];
    logic [9:0] rd_addr;
    logic [7:0] rd_code;

    // Cell row then cell column
    assign rd_addr = {timing.vpos[7:3], timing.hpos[7:3]};
    assign rd_code = tile_ram[rd_addr];

    // Host writes land regardless of pxl_cen
    always_ff @(posedge clk) begin
        if (host.we && (host.sel == SEL_TILEMAP)) begin
            tile_ram[host.addr] <= host.data[7:0];
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            tile <= '0;
        end else if (pxl_cen) begin
            tile.timing <= timing;
            tile.code   <= rd_code;
            tile.row    <= timing.vpos[2:0];   // Row inside the tile
            tile.col    <= timing.hpos[2:0];
        end
    end

endmodule

/* hw/pattern_fetch.sv */
// ======================================================================
// Pattern stage
// 16 patterns of 8x8 pixels at 1 bit per pixel. Reads the row byte of
// the current pattern, picks the pixel bit by column and forms the
// palette index from the tile's palette group.
// ======================================================================
`timescale 1ns/1ps

module pattern_fetch (
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   pxl_cen,
    input  video_pkg::host_wr_t    host,
    input  video_pkg::tile_stage_t tile,
    output video_pkg::pat_stage_t  pix
);
    import video_pkg::*;

    logic [7:0] pat_ram [PATTERN_DEPTH];
    logic [6:0] rd_addr;
    logic [7:0] row_bits;
    logic       pix_bit;

    assign rd_addr  = {tile.code[3:0], tile.row};  // Pattern, then row
    assign row_bits = pat_ram[rd_addr];
    assign pix_bit  = row_bits[~tile.col];         // Bit 7 is column 0

    always_ff @(posedge clk) begin
        if (host.we && (host.sel == SEL_PATTERN)) begin
            pat_ram[host.addr[6:0]] <= host.data[7:0];
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            pix <= '0;
        end else if (pxl_cen) begin
            pix.timing <= tile.timing;
            pix.colour <= {tile.code[7:4], pix_bit};
        end
    end

endmodule

/* hw/palette_out.sv */
// ======================================================================
// Palette stage and video output register
// Looks up the 11-bit colour for the pixel index and drives 12-bit
// RGB with the top bit clear. Output is black while either blanking
// signal is high, and sync leaves together with its pixel.
// ======================================================================
`timescale 1ns/1ps

module palette_out (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  pxl_cen,
    input  video_pkg::host_wr_t   host,
    input  video_pkg::pat_stage_t pix,
    output video_pkg::video_out_t video
);
    import video_pkg::*;

    logic [10:0] pal_ram [PALETTE_DEPTH];
    logic [10:0] colour;
    logic        blank;

    assign colour = pal_ram[pix.colour];
    assign blank  = pix.timing.hbl || pix.timing.vbl;

    always_ff @(posedge clk) begin
        if (host.we && (host.sel == SEL_PALETTE)) begin
            pal_ram[host.addr[4:0]] <= host.data;   // All 11 bits
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            video <= '0;
        end else if (pxl_cen) begin
            video.timing <= pix.timing;
            if (blank) begin
                video.rgb <= '0;
            end else begin
                video.rgb <= {1'b0, colour};
            end
        end
    end

endmodule

/* hw/video_top.sv */
// ======================================================================
// Character video subsystem top level
// Timing generator followed by the tile-map, pattern and palette
// stages. Output is three enables behind the timing register, with
// sync and RGB aligned. The host bus feeds all three RAMs.
// ======================================================================
`timescale 1ns/1ps

module video_top (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  pxl_cen,
    input  logic                  flip,
    input  video_pkg::host_wr_t   host,
    output video_pkg::video_out_t video
);
    import video_pkg::*;

    vid_timing_t timing;   // Stage 0
    tile_stage_t tile;     // Stage 1
    pat_stage_t  pix;      // Stage 2

    video_timing u_timing (
        .clk     (clk),
        .reset   (reset),
        .pxl_cen (pxl_cen),
        .flip    (flip),
        .timing  (timing)
    );

    tile_fetch u_tile (
        .clk     (clk),
        .reset   (reset),
        .pxl_cen (pxl_cen),
        .host    (host),
        .timing  (timing),
        .tile    (tile)
    );

    pattern_fetch u_pattern (
        .clk     (clk),
        .reset   (reset),
        .pxl_cen (pxl_cen),
        .host    (host),
        .tile    (tile),
        .pix     (pix)
    );

    palette_out u_palette (
        .clk     (clk),
        .reset   (reset),
        .pxl_cen (pxl_cen),
        .host    (host),
        .pix     (pix),
        .video   (video)
    );

endmodule

/* verif/video_sva.sv */
// ======================================================================
// Raster assertions, bound into every video_timing instance
// Sync must sit inside blanking and hbl must rise at count 256.
// ======================================================================
`timescale 1ns/1ps

module video_sva (
    input logic                   clk,
    input logic                   reset,
    input logic                   pxl_cen,
    input logic [8:0]             hcnt,
    input video_pkg::vid_timing_t timing
);
    hs_in_hbl: assert property (@(posedge clk) disable iff (reset)
        timing.hs |-> timing.hbl)
        else $error("hs outside horizontal blanking");

    vs_in_vbl: assert property (@(posedge clk) disable iff (reset)
        timing.vs |-> timing.vbl)
        else $error("vs outside vertical blanking");

    // Registered from count 256 on the enabled edge
    hbl_rise: assert property (@(posedge clk) disable iff (reset)
        $rose(timing.hbl) |-> ($past(hcnt) == 9'd256) && $past(pxl_cen))
        else $error("hbl rose away from count 256");

    hbl_at_256: assert property (@(posedge clk) disable iff (reset)
        (hcnt == 9'd256) && pxl_cen |=> timing.hbl)
        else $error("hbl missing after count 256");
endmodule

bind video_timing video_sva u_sva (
    .clk     (clk),
    .reset   (reset),
    .pxl_cen (pxl_cen),
    .hcnt    (hcnt),
    .timing  (timing)
);

/* verif/video_tb.sv */
// ======================================================================
// Directed testbench for the character video subsystem
// Loads the three RAMs with random data, follows the raster with a
// reference model and checks timing, RGB, blanking, flip and a slow
// pixel enable against the video output of video_top.
// ======================================================================
`timescale 1ns/1ps

module video_tb;
    import video_pkg::*;

    localparam int FRAME_CYCLES = 384 * 272;
    localparam int CYCLE_LIMIT  = 3 * FRAME_CYCLES + 5000;

    logic       clk;
    logic       reset;
    logic       pxl_cen;
    logic       flip;
    logic       slow;      // Enable every other cycle
    host_wr_t   host;
    video_out_t video;

    // RAM mirrors
    logic [7:0]  tmap [1024];
    logic [7:0]  pat  [128];
    logic [10:0] pal  [32];

    // Raster model, four enables ahead of the output
    logic [8:0]  mh;
    logic [7:0]  mv;
    logic        msec;
    logic        last_en;
    vid_timing_t d0, d1, d2, d3;

    integer seed = 32'he37c;
    int     cycles = 0;

    video_top UUT (
        .clk     (clk),
        .reset   (reset),
        .pxl_cen (pxl_cen),
        .flip    (flip),
        .host    (host),
        .video   (video)
    );

    always #10 clk = ~clk;

    always @(posedge clk) begin
        pxl_cen <= slow ? ~pxl_cen : 1'b1;
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles >= CYCLE_LIMIT) begin
            $display("Timeout: simulation ran past %0d cycles", CYCLE_LIMIT);
            $display("STATUS: FAIL");
            $fatal(1, "run stopped by cycle limit");
        end
    end

    // Raster rules applied to one count
    function automatic vid_timing_t ref_timing(logic [8:0] h, logic [7:0] v,
                                               logic sec, logic f);
        vid_timing_t t;
        t.hpos = h[7:0] ^ {8{f}};
        t.vpos = v ^ {8{f}};
        t.hbl  = (h >= 9'd256);
        t.hs   = (h >= 9'd309) && (h <= 9'd328);
        t.vbl  = sec || (v >= VBL_START) || (v == V_FIRST);
        t.vs   = sec && (((v == VS_START) && (h >= 9'd309)) ||
                         ((v > VS_START) && (v < VS_END)) ||
                         ((v == VS_END) && (h < 9'd309)));
        return t;
    endfunction

    // Pixel colour from the mirrors, visible area only
    function automatic logic [11:0] ref_rgb(vid_timing_t t);
        logic [7:0] code;
        logic [7:0] bits;
        logic       b;
        code = tmap[{t.vpos[7:3], t.hpos[7:3]}];
        bits = pat[{code[3:0], t.vpos[2:0]}];
        b    = bits[7 - t.hpos[2:0]];       // Bit 7 is leftmost
        return {1'b0, pal[{code[7:4], b}]};
    endfunction

    always @(posedge clk) begin
        if (reset) begin
            mh      = '0;
            mv      = V_REPEAT;
            msec    = 1'b1;
            last_en = 1'b0;
            d0      = '0;
            d1      = '0;
            d2      = '0;
            d3      = '0;
        end else begin
            last_en = pxl_cen;
            if (pxl_cen) begin
                d3 = d2;
                d2 = d1;
                d1 = d0;
                d0 = ref_timing(mh, mv, msec, flip);
                if (mh == 9'd383) begin
                    mh = '0;
                    if (mv == 8'hFF) begin
                        mv   = msec ? V_FIRST : V_REPEAT;
                        msec = ~msec;
                    end else begin
                        mv = mv + 8'd1;
                    end
                end else begin
                    mh = mh + 9'd1;
                end
            end
        end
    end

    task automatic check_timing(string name, vid_timing_t exp, vid_timing_t act);
        if (exp !== act) begin
            $display("Fail %s: expected %h actual %h", name, exp, act);
            $display("STATUS: FAIL");
            $fatal(1, "timing mismatch");
        end
    endtask

    task automatic check_rgb(string name, logic [11:0] exp, logic [11:0] act);
        if (exp !== act) begin
            $display("Fail %s: expected %h actual %h", name, exp, act);
            $display("STATUS: FAIL");
            $fatal(1, "rgb mismatch");
        end
    endtask

    task automatic check_count(string name, int exp, int act);
        if (exp != act) begin
            $display("Fail %s: expected %0d actual %0d", name, exp, act);
            $display("STATUS: FAIL");
            $fatal(1, "count mismatch");
        end
    endtask

    // Timing against the model, then colour or black
    task automatic check_pixel(string name);
        check_timing(name, d3, video.timing);
        if (video.timing.hbl || video.timing.vbl)
            check_rgb({name, " blank"}, 12'h000, video.rgb);
        else
            check_rgb(name, ref_rgb(video.timing), video.rgb);
    endtask

    task automatic wait_sync_rise(bit use_vs);
        logic p;
        p = use_vs ? video.timing.vs : video.timing.hs;
        @(negedge clk);
        while (!((use_vs ? video.timing.vs : video.timing.hs) && !p)) begin
            p = use_vs ? video.timing.vs : video.timing.hs;
            @(negedge clk);
        end
    endtask

    // One line from hs rise to hs rise, scale is clocks per pixel
    task automatic measure_line(string name, int scale);
        int   n, hb, hw;
        logic p, done;
        wait_sync_rise(0);
        n    = 0;
        hb   = 1;
        hw   = 1;
        done = 0;
        while (!done) begin
            p = video.timing.hs;
            @(negedge clk);
            n++;
            if (video.timing.hs && !p) begin
                done = 1;
            end else begin
                hb += video.timing.hbl;
                hw += video.timing.hs;
            end
        end
        check_count({name, " hs period"}, 384 * scale, n);
        check_count({name, " hbl width"}, 128 * scale, hb);
        check_count({name, " hs width"}, 20 * scale, hw);
    endtask

    task automatic test_reset;
        check_timing("reset", '0, video.timing);
        check_rgb("reset", 12'h000, video.rgb);
    endtask

    // Frame first, so the line after the vs rise is not lost
    task automatic test_raster;
        int   lines, vsw;
        logic phs, pvs, done;
        wait_sync_rise(1);
        lines = 0;
        vsw   = 1;
        done  = 0;
        while (!done) begin
            phs = video.timing.hs;
            pvs = video.timing.vs;
            @(negedge clk);
            if (video.timing.hs && !phs) lines++;
            if (video.timing.vs && !pvs) done = 1;
            else vsw += video.timing.vs;
        end
        check_count("raster lines per frame", 272, lines);
        check_count("raster vs width", 4 * 384, vsw);
        measure_line("raster", 1);
    endtask

    task automatic host_write(ram_sel_e s, int a, logic [10:0] d);
        @(posedge clk);
        host <= {1'b1, s, a[9:0], d};
    endtask

    task automatic load_rams;
        for (int i = 0; i < 1024; i++) begin
            tmap[i] = $random(seed);
            host_write(SEL_TILEMAP, i, {3'b0, tmap[i]});
        end
        for (int i = 0; i < 128; i++) begin
            pat[i] = $random(seed);
            host_write(SEL_PATTERN, i, {3'b0, pat[i]});
        end
        for (int i = 0; i < 32; i++) begin
            pal[i] = $random(seed);
            host_write(SEL_PALETTE, i, pal[i]);
        end
        @(posedge clk);
        host <= '0;
        repeat (6) @(negedge clk);   // Flush reads of old contents
    endtask

    task automatic test_pixels;
        repeat (FRAME_CYCLES) begin
            @(negedge clk);
            check_pixel("pixels");
        end
    endtask

    task automatic test_flip;
        @(posedge clk);
        flip <= 1'b1;
        // Run on to the first visible line so colours are compared
        @(negedge clk);
        while (video.timing.vbl) begin
            check_pixel("flip");
            @(negedge clk);
        end
        repeat (384) begin
            @(negedge clk);
            check_pixel("flip");
        end
        @(posedge clk);
        flip <= 1'b0;
    endtask

    task automatic test_slow;
        video_out_t prev;
        @(posedge clk);
        slow <= 1'b1;
        repeat (8) @(negedge clk);
        repeat (2 * 768) begin
            prev = video;
            @(negedge clk);
            if (!last_en) begin
                check_timing("slow hold", prev.timing, video.timing);
                check_rgb("slow hold", prev.rgb, video.rgb);
            end else begin
                check_pixel("slow");
            end
        end
        measure_line("slow", 2);
    endtask

    initial begin
        clk     = 1'b0;
        reset   = 1'b1;
        pxl_cen = 1'b0;
        flip    = 1'b0;
        slow    = 1'b0;
        host    = '0;
        repeat (5) @(posedge clk);
        reset <= 1'b0;
        @(negedge clk);
        test_reset();
        test_raster();
        load_rams();
        test_pixels();
        test_flip();
        test_slow();
        $display("STATUS: PASS");
        $finish;
    end

endmodule

/* compile.f */
hw/video_pkg.sv
hw/video_timing.sv
hw/tile_fetch.sv
hw/pattern_fetch.sv
hw/palette_out.sv
hw/video_top.sv
verif/video_sva.sv
verif/video_tb.sv

/* Makefile */
SRCS := $(wildcard hw/*.sv verif/*.sv)

.PHONY: all run clean

all: run

obj_dir/Vvideo_tb: compile.f $(SRCS)
	verilator --binary --timing --assert --top-module video_tb -f compile.f

run: obj_dir/Vvideo_tb
	-./obj_dir/Vvideo_tb > sim.log 2>&1
	cat sim.log
	grep -q "STATUS: PASS" sim.log

clean:
	rm -rf obj_dir sim.log
